/* logic/lcd_video_pkg.sv */
package lcd_video_pkg;

  typedef logic [9:0] coord_t;
  typedef logic [7:0] seg_addr_t;
  typedef logic [3:0] seg_nibble_t;
  typedef logic [23:0] rgb_t;
  typedef logic [4:0] cell_col_t;
  typedef logic [3:0] cell_row_t;

  // frame geometry, same count horizontally and vertically
  localparam coord_t LINE_TOTAL = 10'd739;
  localparam coord_t ACTIVE_SIZE = 10'd720;
  localparam coord_t SYNC_POS = 10'd725;
  localparam coord_t VSYNC_COL = 10'd720;

  // top left corner of the LCD window on the panel
  localparam coord_t WIN_X0 = 10'd8;
  localparam coord_t WIN_Y0 = 10'd184;

  localparam int LCD_COLS = 32;
  localparam int LCD_ROWS = 16;

  // rows 8 to 15 live in the second bank
  localparam seg_addr_t BANK_OFFSET = 8'h50;

  localparam rgb_t BEZEL_RGB = 24'hE1E6A3;
  localparam rgb_t LIT_RGB = 24'h0A0A0A;
  localparam rgb_t UNLIT_RGB = 24'hA7C9D9;

endpackage

/* logic/raster_timer.sv */
`timescale 1ns/1ps

module raster_timer import lcd_video_pkg::*; #(
  parameter int CELL_SIZE = 22
) (
  input  logic   clk,
  input  logic   reset,
  output coord_t x,
  output coord_t y,
  output coord_t nx,
  output coord_t ny,
  output logic   hsync,
  output logic   vsync,
  output logic   active,
  output logic   in_window,
  output logic   next_in_window,
  output logic   line_start
);

  // right and bottom window edges, exclusive
  localparam coord_t WIN_X1 = coord_t'(WIN_X0 + LCD_COLS * CELL_SIZE);
  localparam coord_t WIN_Y1 = coord_t'(WIN_Y0 + LCD_ROWS * CELL_SIZE);

  function automatic logic inside_window(coord_t cx, coord_t cy);
    return (cx >= WIN_X0) && (cx < WIN_X1) && (cy >= WIN_Y0) && (cy < WIN_Y1);
  endfunction

  // lookahead position, one column ahead of x/y
  always_comb begin
    nx = x + 10'd1;
    ny = y;
    if (x == LINE_TOTAL - 10'd1) begin
      nx = '0;
      ny = (y == LINE_TOTAL - 10'd1) ? '0 : y + 10'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else begin
      x <= nx;
      y <= ny;
    end
  end

  assign hsync = (x == SYNC_POS);
  assign vsync = (x == VSYNC_COL) && (y == SYNC_POS);
  assign active = (x < ACTIVE_SIZE) && (y < ACTIVE_SIZE);
  assign in_window = inside_window(x, y);
  assign next_in_window = inside_window(nx, ny);
  assign line_start = (nx == '0);

endmodule

/* logic/lcd_cell_scaler.sv */
`timescale 1ns/1ps

module lcd_cell_scaler import lcd_video_pkg::*; #(
  parameter int CELL_SIZE = 22
) (
  input  logic      clk,
  input  logic      reset,
  input  coord_t    nx,
  input  coord_t    ny,
  input  logic      next_in_window,
  input  logic      line_start,
  output cell_col_t col,
  output cell_row_t row
);

  localparam int SUB_W = $clog2(CELL_SIZE + 1);
  localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(CELL_SIZE - 1);

  // pixel index inside the current cell, horizontally and vertically
  logic [SUB_W-1:0] sub_x;
  logic [SUB_W-1:0] sub_y;

  logic frame_start;
  logic first_win_col;

  assign frame_start = line_start && (ny == '0);
  assign first_win_col = next_in_window && (nx == WIN_X0);

  // counters park on the last cell so the first window pixel wraps to cell 0
  always_ff @(posedge clk) begin
    if (reset || frame_start) begin
      sub_x <= SUB_LAST;
      col   <= cell_col_t'(LCD_COLS - 1);
      sub_y <= SUB_LAST;
      row   <= cell_row_t'(LCD_ROWS - 1);
    end else if (line_start) begin
      sub_x <= SUB_LAST;
      col   <= cell_col_t'(LCD_COLS - 1);
    end else if (next_in_window) begin
      if (sub_x == SUB_LAST) begin
        sub_x <= '0;
        col   <= (col == cell_col_t'(LCD_COLS - 1)) ? '0 : col + 5'd1;
      end else begin
        sub_x <= sub_x + 1'b1;
      end
      // a new window line may start a new LCD row
      if (first_win_col) begin
        if (sub_y == SUB_LAST) begin
          sub_y <= '0;
          row   <= (row == cell_row_t'(LCD_ROWS - 1)) ? '0 : row + 4'd1;
        end else begin
          sub_y <= sub_y + 1'b1;
        end
      end
    end
  end

endmodule

/* logic/segment_addr_map.sv */
`timescale 1ns/1ps

module segment_addr_map import lcd_video_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cell_col_t  col,
  input  cell_row_t  row,
  output seg_addr_t  rd_addr,
  output logic [1:0] bit_sel
);

  logic [1:0] bit_sel_q;
  seg_addr_t  addr_next;

  // panel column wiring, 40 segment drivers
  function automatic logic [5:0] column_wire(logic [5:0] c);
    case (c)
      6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7: return c;
      6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15: return c + 6'd1;
      // third and fourth groups run backwards
      6'd16, 6'd17, 6'd18, 6'd19, 6'd20, 6'd21, 6'd22, 6'd23: return 6'd52 - c;
      6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd29, 6'd30, 6'd31: return 6'd51 - c;
      6'd32: return 6'd8;
      6'd33: return 6'd17;
      6'd34: return 6'd18;
      6'd35: return 6'd19;
      6'd36: return 6'd28;
      6'd37: return 6'd37;
      6'd38: return 6'd38;
      6'd39: return 6'd39;
      default: return 6'd0;
    endcase
  endfunction

  // two words per column, low bit picks rows 0-3 or 4-7
  always_comb begin
    addr_next = {1'b0, column_wire({1'b0, col}), row[2]};
    if (row[3]) begin
      addr_next = addr_next + BANK_OFFSET;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr   <= '0;
      bit_sel_q <= '0;
      bit_sel   <= '0;
    end else begin
      rd_addr   <= addr_next;
      bit_sel_q <= row[1:0];
      // second stage lines up with the memory read data
      bit_sel   <= bit_sel_q;
    end
  end

endmodule

/* logic/segment_ram.sv */
`timescale 1ns/1ps

module segment_ram import lcd_video_pkg::*; (
  input  logic        clk,
  input  logic        we,
  input  seg_addr_t   waddr,
  input  seg_nibble_t wdata,
  input  seg_addr_t   raddr,
  output seg_nibble_t rdata
);

  seg_nibble_t mem [256];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // same-address collision returns the previous word
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* logic/segment_write_ctrl.sv */
`timescale 1ns/1ps

module segment_write_ctrl import lcd_video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr_req,
  input  seg_addr_t   wr_addr,
  input  seg_nibble_t wr_data,
  output logic        wr_ack,
  output logic        ram_we,
  output seg_addr_t   ram_waddr,
  output seg_nibble_t ram_wdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ACK
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (wr_req) state <= ST_WRITE;
        ST_WRITE: state <= ST_ACK;
        // hold the ack until the host lets go of the request
        ST_ACK:   if (!wr_req) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // capture address and data as the request is accepted
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && wr_req) begin
      ram_waddr <= wr_addr;
      ram_wdata <= wr_data;
    end
  end

  assign ram_we = (state == ST_WRITE);
  assign wr_ack = (state == ST_ACK);

endmodule

/* logic/lcd_shader.sv */
`timescale 1ns/1ps

module lcd_shader import lcd_video_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  seg_nibble_t rd_data,
  input  logic [1:0]  bit_sel,
  input  logic        in_window,
  input  logic        active,
  input  logic        hsync_in,
  input  logic        vsync_in,
  output rgb_t        rgb,
  output logic        hsync,
  output logic        vsync,
  output logic        de
);

  // raster flags wait two cycles for the address and memory stages
  logic [3:0] flags_d1;
  logic [3:0] flags_d2;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags_d1 <= '0;
      flags_d2 <= '0;
      rgb      <= BEZEL_RGB;
      hsync    <= 1'b0;
      vsync    <= 1'b0;
      de       <= 1'b0;
    end else begin
      flags_d1 <= {in_window, active, hsync_in, vsync_in};
      flags_d2 <= flags_d1;
      if (!flags_d2[3]) begin
        rgb <= BEZEL_RGB;
      end else begin
        rgb <= rd_data[bit_sel] ? LIT_RGB : UNLIT_RGB;
      end
      de    <= flags_d2[2];
      hsync <= flags_d2[1];
      vsync <= flags_d2[0];
    end
  end

endmodule

/* logic/lcd_video_top.sv */
`timescale 1ns/1ps

module lcd_video_top import lcd_video_pkg::*; #(
  parameter int CELL_SIZE = 22
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr_req,
  input  seg_addr_t   wr_addr,
  input  seg_nibble_t wr_data,
  output logic        wr_ack,
  output rgb_t        rgb,
  output logic        hsync,
  output logic        vsync,
  output logic        de
);

  coord_t      nx;
  coord_t      ny;
  logic        raw_hsync;
  logic        raw_vsync;
  logic        active;
  logic        in_window;
  logic        next_in_window;
  logic        line_start;
  cell_col_t   col;
  cell_row_t   row;
  seg_addr_t   rd_addr;
  logic [1:0]  bit_sel;
  seg_nibble_t rd_data;
  logic        ram_we;
  seg_addr_t   ram_waddr;
  seg_nibble_t ram_wdata;

  // current x/y are not needed past the timer, the flags carry the position
  raster_timer #(.CELL_SIZE(CELL_SIZE)) u_timer (
    .clk(clk), .reset(reset), .x(), .y(), .nx(nx), .ny(ny),
    .hsync(raw_hsync), .vsync(raw_vsync), .active(active), .in_window(in_window),
    .next_in_window(next_in_window), .line_start(line_start)
  );

  lcd_cell_scaler #(.CELL_SIZE(CELL_SIZE)) u_scaler (
    .clk(clk), .reset(reset), .nx(nx), .ny(ny), .next_in_window(next_in_window),
    .line_start(line_start), .col(col), .row(row)
  );

  segment_addr_map u_map (
    .clk(clk), .reset(reset), .col(col), .row(row), .rd_addr(rd_addr), .bit_sel(bit_sel)
  );

  segment_ram u_ram (
    .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(rd_addr), .rdata(rd_data)
  );

  segment_write_ctrl u_wr_ctrl (
    .clk(clk), .reset(reset), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .wr_ack(wr_ack), .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
  );

  lcd_shader u_shader (
    .clk(clk), .reset(reset), .rd_data(rd_data), .bit_sel(bit_sel),
    .in_window(in_window), .active(active), .hsync_in(raw_hsync), .vsync_in(raw_vsync),
    .rgb(rgb), .hsync(hsync), .vsync(vsync), .de(de)
  );

endmodule

/* bench/lcd_video_tb.sv */
`timescale 1ns/1ps

module lcd_video_tb import lcd_video_pkg::*; ();

  localparam int CELL_SIZE = 22;
  localparam int FRAME_CYCLES = 739 * 739;
  localparam int ACK_TIMEOUT = 16;
  localparam int VSYNC_TIMEOUT = FRAME_CYCLES + 64;
  localparam int VBLANK_WRITES = 24;

  logic        clk = 1'b0;
  logic        reset;
  logic        wr_req;
  seg_addr_t   wr_addr;
  seg_nibble_t wr_data;
  logic        wr_ack;
  rgb_t        rgb;
  logic        hsync;
  logic        vsync;
  logic        de;

  // shadow copy of the segment memory
  seg_nibble_t shadow [256];
  integer      seed = 32'hb40f_4322;

  lcd_video_top #(.CELL_SIZE(CELL_SIZE)) UUT (
    .clk(clk), .reset(reset), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .wr_ack(wr_ack), .rgb(rgb), .hsync(hsync), .vsync(vsync), .de(de)
  );

  always #2 clk = ~clk;

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    stop_on_failure();
  endtask

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // expected panel colour at raster position (px, py)
  function automatic rgb_t model_pixel(input int px, input int py);
    int col;
    int row;
    int wired;
    int addr;
    seg_nibble_t nib;
    if (px < 8 || px >= 8 + 32 * CELL_SIZE || py < 184 || py >= 184 + 16 * CELL_SIZE) begin
      return BEZEL_RGB;
    end
    col = (px - 8) / CELL_SIZE;
    row = (py - 184) / CELL_SIZE;
    if (col < 8) begin
      wired = col;
    end else if (col < 16) begin
      wired = col + 1;
    end else if (col < 24) begin
      wired = 36 - (col - 16);
    end else begin
      wired = 27 - (col - 24);
    end
    addr = wired * 2 + (row / 4) % 2;
    if (row >= 8) begin
      addr = addr + 'h50;
    end
    nib = shadow[addr];
    return nib[row % 4] ? LIT_RGB : UNLIT_RGB;
  endfunction

  task automatic check_idle_outputs();
    check_bit("hsync", hsync, 1'b0);
    check_bit("vsync", vsync, 1'b0);
    check_bit("de", de, 1'b0);
    check_bit("wr_ack", wr_ack, 1'b0);
    check_rgb("rgb", rgb, BEZEL_RGB);
  endtask

  // one four-phase host write, returns on a falling clock edge
  task automatic write_word(input seg_addr_t addr, input seg_nibble_t data);
    int n;
    int hold;
    check_bit("wr_ack", wr_ack, 1'b0);
    @(posedge clk);
    wr_req  <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    n = 0;
    @(negedge clk);
    while (wr_ack !== 1'b1) begin
      n++;
      if (n > ACK_TIMEOUT) begin
        timeout_fail("wr_ack to rise");
      end
      @(negedge clk);
    end
    // ack must stay up while the request is held
    hold = $unsigned($random(seed)) % 3;
    repeat (hold) begin
      @(negedge clk);
      check_bit("wr_ack", wr_ack, 1'b1);
    end
    @(posedge clk);
    wr_req <= 1'b0;
    shadow[addr] = data;
    n = 0;
    @(negedge clk);
    while (wr_ack !== 1'b0) begin
      n++;
      if (n > ACK_TIMEOUT) begin
        timeout_fail("wr_ack to fall");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_vsync();
    int n;
    n = 0;
    @(negedge clk);
    while (vsync !== 1'b1) begin
      n++;
      if (n > VSYNC_TIMEOUT) begin
        timeout_fail("the first vsync pulse");
      end
      @(negedge clk);
    end
  endtask

  // entered on the vsync sample, position (720,725), and left on the next one
  task automatic check_frame();
    int px;
    int py;
    int cycles;
    int since_h;
    int de_run;
    bit seen_h;
    px = 720;
    py = 725;
    since_h = 0;
    de_run = 0;
    seen_h = 1'b0;
    for (cycles = 0; cycles < FRAME_CYCLES; cycles++) begin
      // spacing of the sync pulses and length of each de run
      if (hsync) begin
        if (seen_h) begin
          check_count("hsync period", since_h, 739);
        end
        seen_h = 1'b1;
        since_h = 0;
      end
      since_h++;
      if (vsync && cycles != 0) begin
        check_count("vsync period", cycles, FRAME_CYCLES);
      end
      if (de) begin
        de_run++;
      end else if (de_run != 0) begin
        check_count("de run length", de_run, 720);
        de_run = 0;
      end
      check_rgb("rgb", rgb, model_pixel(px, py));
      check_bit("hsync", hsync, px == 725);
      check_bit("vsync", vsync, (px == 720) && (py == 725));
      check_bit("de", de, (px < 720) && (py < 720));
      px++;
      if (px == 739) begin
        px = 0;
        py = (py == 738) ? 0 : py + 1;
      end
      @(negedge clk);
    end
    // the next vsync closes the frame period
    check_bit("vsync", vsync, 1'b1);
  endtask

  initial begin
    reset   = 1'b1;
    wr_req  = 1'b0;
    wr_addr = '0;
    wr_data = '0;

    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle_outputs();
    @(negedge clk);
    check_idle_outputs();

    // fill every word so the whole frame is defined
    for (int i = 0; i < 256; i++) begin
      write_word(seg_addr_t'(i), seg_nibble_t'($random(seed)));
    end

    wait_vsync();
    check_frame();

    // vertical blank updates land before the next window lines
    fork
      check_frame();
      begin
        repeat (VBLANK_WRITES) begin
          write_word(seg_addr_t'($random(seed)), seg_nibble_t'($random(seed)));
        end
      end
    join

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* lcd_video.f */
logic/lcd_video_pkg.sv
logic/raster_timer.sv
logic/lcd_cell_scaler.sv
logic/segment_addr_map.sv
logic/segment_ram.sv
logic/segment_write_ctrl.sv
logic/lcd_shader.sv
logic/lcd_video_top.sv
bench/lcd_video_tb.sv
